// File: Makefile
TOOL      := verilator
TOP       := msx_slot_tb
DUT_TOP   := msx_slot_top
FILELIST  := msx_slot.f
FLAGS     := --timing
SIM_FLAGS := --binary -j 0
OBJ_DIR   := obj_dir
PASS_MSG  := Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/msx_bus_pkg.sv
package msx_bus_pkg;

    // External memory width, default of MEM_ADDR_W at the top
    localparam int MEM_ADDR_W = 27;

    // Z80 side
    typedef logic [15:0] cpu_addr_t;               // 64 KB CPU space
    typedef logic [7:0]  cpu_data_t;               // Byte wide data

    // Page number from CPU address bits 15:14
    typedef logic [1:0]  page_t;

    // Offsets and addresses toward external memory
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // Value seen by the CPU on an unmapped read
    localparam cpu_data_t IDLE_DATA = 8'hFF;

    // Base of the cartridge area, start of plain ROM images
    localparam cpu_addr_t ROM_AREA_BASE = 16'h4000;

endpackage

// File: design/msx_cfg_pkg.sv
package msx_cfg_pkg;

    // Table sizes
    localparam int NUM_SLOTS = 4;                  // Primary slots
    localparam int NUM_CARTS = 2;                  // Cartridges with own bank registers
    localparam int NUM_BANKS = 4;                  // 8 KB windows in 0x4000..0xBFFF

    // Mapper encoding as stored in the block register
    typedef enum logic [2:0] {
        MAPPER_NONE   = 3'd0,                      // Empty slot
        MAPPER_ROM    = 3'd1,                      // Plain ROM
        MAPPER_ASCII8 = 3'd2,                      // ASCII8 with SRAM
        MAPPER_KONAMI = 3'd3,                      // Konami without SCC
        MAPPER_RAM    = 3'd4                       // Plain RAM
    } mapper_t;

    // One slot's layout, 6 bits
    typedef struct packed {
        mapper_t    mapper;
        logic       cart_num;                      // Selects bank register set
        logic [1:0] offset_ram;                    // 16 KB page offset for plain ROM
    } block_t;

    // RAM window of a slot
    typedef struct packed {
        logic [26:0] addr;                         // Base in external memory
        logic [15:0] size;                         // Count of 16 KB blocks
        logic        ro;                           // Writes suppressed
    } lookup_ram_t;

    // SRAM window of a slot
    typedef struct packed {
        logic [26:0] addr;                         // Base in external memory
        logic [15:0] size;                         // Bytes, zero means no SRAM
    } lookup_sram_t;

    typedef logic [7:0] apb_addr_t;

    // APB map
    localparam apb_addr_t REG_SLOT    = 8'h00;     // Primary slot register
    localparam apb_addr_t SLOT_STRIDE = 8'h10;     // Slot n group at (n+1)*stride
    localparam apb_addr_t APB_LAST    = 8'h4F;     // Last decoded offset

    // Offsets inside one slot group
    localparam logic [3:0] REG_BLOCK     = 4'h0;   // block_t in bits 5:0
    localparam logic [3:0] REG_RAM_BASE  = 4'h4;
    localparam logic [3:0] REG_RAM_SIZE  = 4'h8;   // ro flag in bit 16
    localparam logic [3:0] REG_SRAM_BASE = 4'hC;
    localparam logic [3:0] REG_SRAM_SIZE = 4'h0;   // Bits 31:16 of the block word

endpackage

// File: design/msx_ifs.sv
`timescale 1ns/1ps

// CPU request as seen by the slot logic
interface cpu_bus_if;
    logic                   req;                   // One cycle strobe
    msx_bus_pkg::cpu_addr_t addr;
    logic                   rnw;                   // High for read
    msx_bus_pkg::cpu_data_t wdata;

    modport source (
        output req, addr, rnw, wdata
    );

    modport sink (
        input  req, addr, rnw, wdata
    );
endinterface

// Offset and selects from the mapper
interface memory_bus_if;
    msx_bus_pkg::mem_addr_t addr;                  // Offset inside the window
    logic                   rnw;
    logic                   ram_cs;                // Hit in RAM window
    logic                   sram_cs;               // Hit in SRAM window

    modport source (
        output addr, rnw, ram_cs, sram_cs
    );

    modport sink (
        input  addr, rnw, ram_cs, sram_cs
    );
endinterface

// Active slot layout handed to the mapper
interface block_info_if;
    msx_cfg_pkg::mapper_t   typ;
    logic                   cart_num;
    logic [1:0]             offset_ram;
    msx_bus_pkg::mem_addr_t rom_size;              // Bytes, zero disables wrap
    logic [15:0]            sram_size;             // Bytes

    modport source (
        output typ, cart_num, offset_ram, rom_size, sram_size
    );

    modport sink (
        input  typ, cart_num, offset_ram, rom_size, sram_size
    );
endinterface

// File: design/msx_mappers.sv
`timescale 1ns/1ps

module msx_mappers (
    input  logic         clk,
    input  logic         rst_n,
    cpu_bus_if.sink      cpu_bus,
    block_info_if.sink   block_info,
    memory_bus_if.source memory_bus
);

    // Bank registers, one set per cartridge
    msx_bus_pkg::cpu_data_t bank_q [msx_cfg_pkg::NUM_CARTS][msx_cfg_pkg::NUM_BANKS];

    logic                   cpu_wr;
    logic                   in_area;                // 0x4000..0xBFFF
    logic [1:0]             win;                    // 8 KB window in the area
    msx_bus_pkg::cpu_data_t bank;
    msx_bus_pkg::mem_addr_t mask;                   // Wrap mask from ROM size
    msx_bus_pkg::mem_addr_t rom_off;
    msx_bus_pkg::mem_addr_t bank_off;
    logic                   sram_sel;

    assign cpu_wr  = cpu_bus.req & ~cpu_bus.rnw;
    assign in_area = (cpu_bus.addr[15:14] == 2'b01) || (cpu_bus.addr[15:14] == 2'b10);
    assign win     = 2'(cpu_bus.addr[15:13] - 3'd2);

    // Bank writes in the request cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < msx_cfg_pkg::NUM_CARTS; c++) begin
                for (int b = 0; b < msx_cfg_pkg::NUM_BANKS; b++)
                    bank_q[c][b] <= '0;
            end
        end else if (cpu_wr) begin
            case (block_info.typ)
                msx_cfg_pkg::MAPPER_ASCII8: begin
                    // 0x6000/0x6800/0x7000/0x7800 pick the bank by bits 12:11
                    if (cpu_bus.addr[15:13] == 3'b011)
                        bank_q[block_info.cart_num][cpu_bus.addr[12:11]] <= cpu_bus.wdata;
                end
                msx_cfg_pkg::MAPPER_KONAMI: begin
                    if (in_area && win != 2'd0)     // First window is fixed
                        bank_q[block_info.cart_num][win] <= cpu_bus.wdata;
                end
                default: ;
            endcase
        end
    end

    // Konami keeps bank 0 at 0x4000
    always_comb begin
        bank = bank_q[block_info.cart_num][win];
        if (block_info.typ == msx_cfg_pkg::MAPPER_KONAMI && win == 2'd0)
            bank = '0;
    end

    assign mask     = block_info.rom_size - msx_bus_pkg::mem_addr_t'(1);   // Zero size wraps never
    assign rom_off  = msx_bus_pkg::mem_addr_t'(cpu_bus.addr)
                    - msx_bus_pkg::mem_addr_t'(msx_bus_pkg::ROM_AREA_BASE)
                    + msx_bus_pkg::mem_addr_t'({block_info.offset_ram, 14'd0});
    assign bank_off = msx_bus_pkg::mem_addr_t'({bank, cpu_bus.addr[12:0]});
    assign sram_sel = bank[7] && (block_info.sram_size != 16'd0);

    // Address translation per mapper type
    always_comb begin
        memory_bus.addr    = '0;
        memory_bus.rnw     = 1'b1;                  // ROM types never write
        memory_bus.ram_cs  = 1'b0;
        memory_bus.sram_cs = 1'b0;
        case (block_info.typ)
            msx_cfg_pkg::MAPPER_ROM: begin
                memory_bus.ram_cs = 1'b1;
                memory_bus.addr   = rom_off & mask;
            end
            msx_cfg_pkg::MAPPER_ASCII8: begin
                if (in_area) begin
                    if (sram_sel) begin
                        memory_bus.sram_cs = 1'b1;
                        memory_bus.addr    = msx_bus_pkg::mem_addr_t'(cpu_bus.addr[12:0]);
                        // SRAM writable only at 0x8000..0xBFFF
                        memory_bus.rnw     = cpu_bus.rnw | ~cpu_bus.addr[15];
                    end else begin
                        memory_bus.ram_cs = 1'b1;
                        memory_bus.addr   = bank_off & mask;
                    end
                end
            end
            msx_cfg_pkg::MAPPER_KONAMI: begin
                if (in_area) begin
                    memory_bus.ram_cs = 1'b1;
                    memory_bus.addr   = bank_off & mask;
                end
            end
            msx_cfg_pkg::MAPPER_RAM: begin
                memory_bus.ram_cs = 1'b1;
                memory_bus.rnw    = cpu_bus.rnw;
                memory_bus.addr   = msx_bus_pkg::mem_addr_t'(cpu_bus.addr) & mask;
            end
            default: ;                              // Empty slot
        endcase
    end

endmodule

// File: design/msx_slot_config.sv
`timescale 1ns/1ps

module msx_slot_config (
    input  logic                      clk,
    input  logic                      rst_n,
    input  msx_cfg_pkg::apb_addr_t    paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  msx_bus_pkg::page_t        page,          // CPU address bits 15:14
    output msx_cfg_pkg::block_t       active_block,
    output msx_cfg_pkg::lookup_ram_t  active_ram,
    output msx_cfg_pkg::lookup_sram_t active_sram
);

    logic [7:0] slot_reg;                           // Two bits per page

    // Per slot tables
    msx_cfg_pkg::block_t       blocks [msx_cfg_pkg::NUM_SLOTS];
    msx_cfg_pkg::lookup_ram_t  rams   [msx_cfg_pkg::NUM_SLOTS];
    msx_cfg_pkg::lookup_sram_t srams  [msx_cfg_pkg::NUM_SLOTS];

    logic       access;
    logic       err;
    logic       wr_en;
    logic       in_slot;                            // Offset inside a slot group
    logic [1:0] sidx;
    logic [3:0] off;
    logic [1:0] active_slot;

    // APB decode
    assign access  = psel & penable;
    assign err     = (paddr > msx_cfg_pkg::APB_LAST) || (paddr[1:0] != 2'b00);
    assign wr_en   = access & pwrite & ~err;
    assign in_slot = paddr >= msx_cfg_pkg::SLOT_STRIDE;
    assign sidx    = 2'((paddr - msx_cfg_pkg::SLOT_STRIDE) / msx_cfg_pkg::SLOT_STRIDE);
    assign off     = paddr[3:0];

    assign pready  = 1'b1;                          // No wait states
    assign pslverr = access & err;

    // Register writes at the end of the access phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_reg <= '0;
            for (int i = 0; i < msx_cfg_pkg::NUM_SLOTS; i++) begin
                blocks[i] <= '0;                    // Mapper none
                rams[i]   <= '0;
                srams[i]  <= '0;
            end
        end else if (wr_en) begin
            if (!in_slot) begin
                if (paddr == msx_cfg_pkg::REG_SLOT)
                    slot_reg <= pwdata[7:0];
            end else begin
                if (off == msx_cfg_pkg::REG_BLOCK)
                    blocks[sidx] <= msx_cfg_pkg::block_t'(pwdata[5:0]);
                if (off == msx_cfg_pkg::REG_SRAM_SIZE)
                    srams[sidx].size <= pwdata[31:16];
                if (off == msx_cfg_pkg::REG_RAM_BASE)
                    rams[sidx].addr <= pwdata[26:0];
                if (off == msx_cfg_pkg::REG_RAM_SIZE) begin
                    rams[sidx].size <= pwdata[15:0];
                    rams[sidx].ro   <= pwdata[16];   // Read-only flag
                end
                if (off == msx_cfg_pkg::REG_SRAM_BASE)
                    srams[sidx].addr <= pwdata[26:0];
            end
        end
    end

    // Read mux, unused offsets read zero
    always_comb begin
        prdata = '0;
        if (!in_slot) begin
            if (paddr == msx_cfg_pkg::REG_SLOT)
                prdata[7:0] = slot_reg;
        end else begin
            if (off == msx_cfg_pkg::REG_BLOCK)
                prdata[5:0] = blocks[sidx];
            if (off == msx_cfg_pkg::REG_SRAM_SIZE)
                prdata[31:16] = srams[sidx].size;
            if (off == msx_cfg_pkg::REG_RAM_BASE)
                prdata = 32'(rams[sidx].addr);
            if (off == msx_cfg_pkg::REG_RAM_SIZE)
                prdata = {15'd0, rams[sidx].ro, rams[sidx].size};
            if (off == msx_cfg_pkg::REG_SRAM_BASE)
                prdata = 32'(srams[sidx].addr);
        end
    end

    // Slot for the page of the current request
    assign active_slot  = slot_reg[2*page +: 2];
    assign active_block = blocks[active_slot];
    assign active_ram   = rams[active_slot];
    assign active_sram  = srams[active_slot];

endmodule

// File: design/msx_slot_top.sv
`timescale 1ns/1ps

module msx_slot_top #(
    parameter int MEM_ADDR_W = $bits(msx_bus_pkg::mem_addr_t)
) (
    input  logic                   clk,
    input  logic                   rst_n,
    // APB slave
    input  msx_cfg_pkg::apb_addr_t paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    // CPU port
    input  logic                   cpu_req,
    input  msx_bus_pkg::cpu_addr_t cpu_addr,
    input  logic                   cpu_rnw,
    input  msx_bus_pkg::cpu_data_t cpu_wdata,
    output msx_bus_pkg::cpu_data_t cpu_rdata,
    output logic                   cpu_ack,
    // External memory
    output logic [MEM_ADDR_W-1:0]  ram_addr,
    output msx_bus_pkg::cpu_data_t ram_din,
    input  msx_bus_pkg::cpu_data_t ram_dout,
    output logic                   ram_rnw,
    output logic                   ram_ce
);

    cpu_bus_if    cpu_bus ();
    memory_bus_if memory_bus ();
    block_info_if block_info ();

    msx_cfg_pkg::block_t       active_block;        // Entries of the selected slot
    msx_cfg_pkg::lookup_ram_t  active_ram;
    msx_cfg_pkg::lookup_sram_t active_sram;

    // CPU port onto the internal bus
    assign cpu_bus.req   = cpu_req;
    assign cpu_bus.addr  = cpu_addr;
    assign cpu_bus.rnw   = cpu_rnw;
    assign cpu_bus.wdata = cpu_wdata;

    msx_slot_config u_config (
        .clk          (clk),
        .rst_n        (rst_n),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .page         (cpu_bus.addr[15:14]),
        .active_block (active_block),
        .active_ram   (active_ram),
        .active_sram  (active_sram)
    );

    msx_mappers u_mappers (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_bus    (cpu_bus),
        .block_info (block_info),
        .memory_bus (memory_bus)
    );

    msx_slots #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) u_slots (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_bus      (cpu_bus),
        .memory_bus   (memory_bus),
        .block_info   (block_info),
        .active_block (active_block),
        .active_ram   (active_ram),
        .active_sram  (active_sram),
        .ram_addr     (ram_addr),
        .ram_din      (ram_din),
        .ram_dout     (ram_dout),
        .ram_rnw      (ram_rnw),
        .ram_ce       (ram_ce),
        .cpu_rdata    (cpu_rdata),
        .cpu_ack      (cpu_ack)
    );

endmodule

// File: design/msx_slots.sv
`timescale 1ns/1ps

module msx_slots #(
    parameter int MEM_ADDR_W = $bits(msx_bus_pkg::mem_addr_t)
) (
    input  logic                      clk,
    input  logic                      rst_n,
    cpu_bus_if.sink                   cpu_bus,
    memory_bus_if.sink                memory_bus,
    block_info_if.source              block_info,
    input  msx_cfg_pkg::block_t       active_block,
    input  msx_cfg_pkg::lookup_ram_t  active_ram,
    input  msx_cfg_pkg::lookup_sram_t active_sram,
    output logic [MEM_ADDR_W-1:0]     ram_addr,
    output msx_bus_pkg::cpu_data_t    ram_din,
    input  msx_bus_pkg::cpu_data_t    ram_dout,
    output logic                      ram_rnw,
    output logic                      ram_ce,
    output msx_bus_pkg::cpu_data_t    cpu_rdata,
    output logic                      cpu_ack
);

    logic        ack_q;                             // Request seen last cycle
    logic        hit_q;                             // That request reached memory
    logic [26:0] base;                              // Window base for this access

    // Layout of the active slot for the mapper
    assign block_info.typ        = active_block.mapper;
    assign block_info.cart_num   = active_block.cart_num;
    assign block_info.offset_ram = active_block.offset_ram;
    assign block_info.rom_size   = {active_ram.size[12:0], 14'd0};   // Blocks of 16 KB
    assign block_info.sram_size  = active_sram.size;

    // Window base picked by the mapper's select
    assign base = memory_bus.sram_cs ? active_sram.addr : active_ram.addr;

    // External memory side, valid in the request cycle
    assign ram_addr = MEM_ADDR_W'(base + memory_bus.addr);
    assign ram_din  = cpu_bus.wdata;
    assign ram_ce   = cpu_bus.req & (memory_bus.ram_cs | memory_bus.sram_cs);
    assign ram_rnw  = memory_bus.rnw | (memory_bus.ram_cs & active_ram.ro);   // RO window

    // Fixed one cycle response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
            hit_q <= 1'b0;
        end else begin
            ack_q <= cpu_bus.req;
            hit_q <= ram_ce;
        end
    end

    assign cpu_ack   = ack_q;
    assign cpu_rdata = hit_q ? ram_dout : msx_bus_pkg::IDLE_DATA;   // Open bus reads FF

endmodule

// File: msx_slot.f
design/msx_cfg_pkg.sv
design/msx_bus_pkg.sv
design/msx_ifs.sv
design/msx_slot_config.sv
design/msx_mappers.sv
design/msx_slots.sv
design/msx_slot_top.sv
verif/msx_slot_tb.sv

// File: verif/msx_slot_cases.txt
# op addr data expected, all hex
# A/B/E apb write, read, error; R/W cpu access, expected = ram_addr; X cpu miss
A 10 00000009 0
A 14 00100000 0
A 20 20000010 0
A 24 00200000 0
A 2C 00400000 0
A 30 0000001C 0
A 34 00300000 0
A 40 00000020 0
A 44 00500000 0
A 48 00000002 0
A 00 000000C3 0
B 00 0 000000C3
B 20 0 20000010
E 50 12345678 0
E 22 12345678 0
R 4123 0 0104123
W 0100 A5 0500100
R 0100 0 0500100
A 00 000000D7 0
W 6000 03 0200000
W 7000 07 0201000
R 4010 0 0206010
R 8030 0 020E030
A 00 000000EB 0
W 8000 04 0300000
W A000 06 0300000
W 4000 09 0300000
R 4100 0 0300100
R 8100 0 0308100
R A100 0 030C100
A 00 000000D7 0
R 8030 0 020E030
W 7000 80 0201000
W 8123 5A 0400123
R 8123 0 0400123
A 10 00000000 0
A 00 000000C3 0
X 4000 0 0
A 00 000000FF 0
R 8100 0 0500100
A 48 00010002 0
B 48 0 00010002
W 0200 3C 0500200
R 0200 0 0500200

// File: verif/msx_slot_tb.sv
`timescale 1ns/1ps

module msx_slot_tb;

    localparam int    CLK_PERIOD   = 20;
    localparam int    RESET_CYCLES = 16;
    localparam int    DRIVE_DELAY  = 2;             // Inputs change after the rising edge
    localparam int    FILL_BYTES   = 1024;          // Random table behind the fill pattern
    localparam string CASE_FILE    = "verif/msx_slot_cases.txt";

    logic                   clk;
    logic                   rst_n;
    msx_cfg_pkg::apb_addr_t paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   cpu_req;
    msx_bus_pkg::cpu_addr_t cpu_addr;
    logic                   cpu_rnw;
    msx_bus_pkg::cpu_data_t cpu_wdata;
    msx_bus_pkg::cpu_data_t cpu_rdata;
    logic                   cpu_ack;
    msx_bus_pkg::mem_addr_t ram_addr;
    msx_bus_pkg::cpu_data_t ram_din;
    msx_bus_pkg::cpu_data_t ram_dout = '0;          // Memory model output
    logic                   ram_rnw;
    logic                   ram_ce;

    // Memory model holds a random fill plus bytes written by the DUT
    msx_bus_pkg::cpu_data_t fill [FILL_BYTES];
    msx_bus_pkg::cpu_data_t mem [msx_bus_pkg::mem_addr_t];
    integer                 seed;

    // Cases from the file
    logic [7:0]  ops   [$];
    logic [31:0] addrs [$];
    logic [31:0] datas [$];
    logic [31:0] exps  [$];
    int          num_cases;
    bit          cases_loaded;
    int          case_idx;

    // Slot setup as written by the A cases
    logic [7:0]             slot_sel;
    msx_cfg_pkg::mapper_t   slot_map [msx_cfg_pkg::NUM_SLOTS];
    logic                   slot_ro  [msx_cfg_pkg::NUM_SLOTS];
    msx_bus_pkg::mem_addr_t sram_lo  [msx_cfg_pkg::NUM_SLOTS];
    logic [15:0]            sram_len [msx_cfg_pkg::NUM_SLOTS];

    // Memory side seen in the last CPU request cycle
    msx_bus_pkg::mem_addr_t req_addr;
    logic                   req_ce;
    logic                   req_rnw;
    msx_bus_pkg::cpu_data_t req_din;
    msx_bus_pkg::cpu_data_t resp_data;              // cpu_rdata in the ack cycle

    msx_slot_top #(
        .MEM_ADDR_W ($bits(msx_bus_pkg::mem_addr_t))
    ) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Unwritten bytes mix the random table with every address bit
    function automatic msx_bus_pkg::cpu_data_t model_byte(input msx_bus_pkg::mem_addr_t a);
        if (mem.exists(a))
            return mem[a];
        return fill[a[9:0]] ^ a[17:10] ^ a[25:18] ^ {7'd0, a[26]};
    endfunction

    // Read data comes one cycle after ce and writes land at the ce edge
    always @(posedge clk) begin
        if (ram_ce && ram_rnw)
            ram_dout <= model_byte(ram_addr);
        else if (ram_ce)
            mem[ram_addr] = ram_din;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped in case %0d", case_idx);
    endtask

    task automatic check_data(input string name, input msx_bus_pkg::cpu_data_t got,
                              input msx_bus_pkg::cpu_data_t exp);
        if (got !== exp)
            abort_run($sformatf("ERROR %s got 0x%h expected 0x%h in case %0d",
                                name, got, exp, case_idx));
    endtask

    task automatic check_mem_addr(input string name, input msx_bus_pkg::mem_addr_t got,
                                  input msx_bus_pkg::mem_addr_t exp);
        if (got !== exp)
            abort_run($sformatf("ERROR %s got 0x%h expected 0x%h in case %0d",
                                name, got, exp, case_idx));
    endtask

    task automatic check_apb(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("ERROR %s got 0x%h expected 0x%h in case %0d",
                                name, got, exp, case_idx));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("ERROR %s got 0x%h expected 0x%h in case %0d",
                                name, got, exp, case_idx));
    endtask

    task automatic read_cases();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0)
            abort_run("Could not open the case file");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#")
                continue;                           // Blank or column note
            n = $sscanf(line, "%s %h %h %h", op, a, d, e);
            if (n != 4)
                abort_run($sformatf("Case file line does not hold four fields: %s", line));
            ops.push_back(op);
            addrs.push_back(a);
            datas.push_back(d);
            exps.push_back(e);
        end
        $fclose(fd);
        num_cases = ops.size();
        if (num_cases == 0)
            abort_run("The case file holds no cases");
        cases_loaded = 1'b1;
    endtask

    // Follow the APB register map for slot register, mapper, ro flag and SRAM window
    task automatic track_config(input msx_cfg_pkg::apb_addr_t a, input logic [31:0] d);
        int s;
        s = int'(a[7:4]) - 1;                       // Slot group, -1 below the first
        if (a == msx_cfg_pkg::REG_SLOT)
            slot_sel = d[7:0];
        else if (s >= 0 && a[3:0] == msx_cfg_pkg::REG_BLOCK) begin
            slot_map[s] = msx_cfg_pkg::mapper_t'(d[5:3]);
            sram_len[s] = d[31:16];                 // Block word carries the SRAM size
        end else if (s >= 0 && a[3:0] == msx_cfg_pkg::REG_RAM_SIZE)
            slot_ro[s] = d[16];
        else if (s >= 0 && a[3:0] == msx_cfg_pkg::REG_SRAM_BASE)
            sram_lo[s] = msx_bus_pkg::mem_addr_t'(d[26:0]);
    endtask

    // Writes land only in a writable RAM window or in SRAM at 0x8000..0xBFFF
    function automatic logic write_blocked(input msx_bus_pkg::cpu_addr_t a,
                                           input msx_bus_pkg::mem_addr_t m);
        int   s;
        logic in_sram;
        s       = slot_sel[2 * int'(a[15:14]) +: 2];
        in_sram = sram_len[s] != 16'd0 && m >= sram_lo[s]
                  && m < sram_lo[s] + msx_bus_pkg::mem_addr_t'(sram_len[s]);
        case (slot_map[s])
            msx_cfg_pkg::MAPPER_RAM:    return slot_ro[s];
            msx_cfg_pkg::MAPPER_ASCII8: return ~(a[15] & in_sram);
            default:                    return 1'b1;   // ROM types and empty slot
        endcase
    endfunction

    // Setup phase then access phase with sampling before the ending edge
    task automatic apb_access(input logic wr, input msx_cfg_pkg::apb_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #DRIVE_DELAY;
        penable = 1'b1;
        @(negedge clk);
        if (!pready)
            abort_run("APB slave held pready low");
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #DRIVE_DELAY;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic cpu_access(input logic rnw, input msx_bus_pkg::cpu_addr_t addr,
                              input msx_bus_pkg::cpu_data_t wdata);
        cpu_req   = 1'b1;
        cpu_rnw   = rnw;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        @(negedge clk);                             // Memory side settled in request cycle
        req_addr = ram_addr;
        req_ce   = ram_ce;
        req_rnw  = ram_rnw;
        req_din  = ram_din;
        @(posedge clk);
        #DRIVE_DELAY;
        cpu_req = 1'b0;
        if (!cpu_ack)
            abort_run($sformatf("CPU access to %h in case %0d was not acknowledged %s",
                                addr, case_idx, "one cycle after the request"));
        resp_data = cpu_rdata;
    endtask

    // Bound from the case count once the file is read
    initial begin
        wait (cases_loaded);
        repeat (RESET_CYCLES + 10 * num_cases) @(posedge clk);
        abort_run("Watchdog expired before all cases finished");
    end

    initial begin
        logic [31:0]            rd;
        logic                   err;
        msx_bus_pkg::cpu_data_t exp_byte;
        msx_bus_pkg::mem_addr_t exp_addr;
        rst_n     = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        cpu_req   = 1'b0;
        cpu_addr  = '0;
        cpu_rnw   = 1'b1;
        cpu_wdata = '0;
        case_idx  = 0;
        seed      = 32'h5fc5_2523;
        for (int i = 0; i < FILL_BYTES; i++)
            fill[i] = 8'($random(seed));
        slot_sel = '0;                              // Every slot empty out of reset
        for (int i = 0; i < msx_cfg_pkg::NUM_SLOTS; i++) begin
            slot_map[i] = msx_cfg_pkg::MAPPER_NONE;
            slot_ro[i]  = 1'b0;
            sram_lo[i]  = '0;
            sram_len[i] = '0;
        end
        read_cases();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        check_flag("cpu_ack", cpu_ack, 1'b0);       // Idle state out of reset
        check_flag("ram_ce", ram_ce, 1'b0);
        check_flag("ram_rnw", ram_rnw, 1'b1);
        check_flag("pslverr", pslverr, 1'b0);
        for (int i = 0; i < num_cases; i++) begin
            case_idx = i + 1;
            exp_addr = msx_bus_pkg::mem_addr_t'(exps[i]);
            case (ops[i])
                "A": begin
                    apb_access(1'b1, msx_cfg_pkg::apb_addr_t'(addrs[i]), datas[i], rd, err);
                    check_flag("pslverr", err, 1'b0);
                    track_config(msx_cfg_pkg::apb_addr_t'(addrs[i]), datas[i]);
                end
                "B": begin
                    apb_access(1'b0, msx_cfg_pkg::apb_addr_t'(addrs[i]), '0, rd, err);
                    check_flag("pslverr", err, 1'b0);
                    check_apb("prdata", rd, exps[i]);
                end
                "E": begin
                    apb_access(1'b1, msx_cfg_pkg::apb_addr_t'(addrs[i]), datas[i], rd, err);
                    check_flag("pslverr", err, 1'b1);
                end
                "R": begin
                    exp_byte = model_byte(exp_addr);    // Holds earlier writes
                    cpu_access(1'b1, msx_bus_pkg::cpu_addr_t'(addrs[i]), 8'h00);
                    check_flag("ram_ce", req_ce, 1'b1);
                    check_flag("ram_rnw", req_rnw, 1'b1);
                    check_mem_addr("ram_addr", req_addr, exp_addr);
                    check_data("cpu_rdata", resp_data, exp_byte);
                end
                "W": begin
                    cpu_access(1'b0, msx_bus_pkg::cpu_addr_t'(addrs[i]),
                               msx_bus_pkg::cpu_data_t'(datas[i]));
                    check_flag("ram_ce", req_ce, 1'b1);
                    check_flag("ram_rnw", req_rnw,
                               write_blocked(msx_bus_pkg::cpu_addr_t'(addrs[i]), exp_addr));
                    check_mem_addr("ram_addr", req_addr, exp_addr);
                    check_data("ram_din", req_din, msx_bus_pkg::cpu_data_t'(datas[i]));
                end
                "X": begin
                    cpu_access(1'b1, msx_bus_pkg::cpu_addr_t'(addrs[i]), 8'h00);
                    check_flag("ram_ce", req_ce, 1'b0);
                    check_data("cpu_rdata", resp_data, 8'hFF);     // Open bus
                end
                default: abort_run($sformatf("Unknown op in case %0d", case_idx));
            endcase
        end
        $display("Test passed");
        $finish;
    end

endmodule
